//--- rtl/div_msg_pkg.sv
/*
  divider message types shared by the divider blocks and the testbench
*/

`default_nettype none

package div_msg_pkg;

  // ------------------------------------------------------------------------
  // request fields
  // ------------------------------------------------------------------------

  // function bit of a request
  typedef logic div_fn_t;

  // signed division request code
  localparam div_fn_t DIV_FN_SIGNED = 1'b1;

  // operand, quotient and remainder all share this width
  typedef logic [31:0] div_operand_t;

  // ------------------------------------------------------------------------
  // response and working storage
  // ------------------------------------------------------------------------

  // remainder in [63:32], quotient in [31:0]
  typedef logic [63:0] div_result_t;

  // shift-subtract accumulator
  // bit 64 holds the borrow of the trial subtraction
  typedef logic [64:0] div_acc_t;

endpackage

`default_nettype wire

//--- rtl/div_ctrl_pkg.sv
/*
  divider control encodings shared by the control unit and the datapath
*/

`default_nettype none

package div_ctrl_pkg;

  // one quotient bit per step
  localparam int unsigned DIV_STEPS = 32;

  // step counter, wide enough for DIV_STEPS - 1
  typedef logic [4:0] div_count_t;

  // accumulator load source
  typedef enum logic {
    A_SEL_LOAD,
    A_SEL_STEP
  } div_a_sel_e;

  // control unit states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } div_state_e;

endpackage

`default_nettype wire

//--- rtl/int_div_sign.sv
/*
  divider sign unit
  turns operands into magnitudes and restores the result signs
*/

`timescale 1ns/10ps
`default_nettype none

module int_div_sign
  import div_msg_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         sign_en,
  input  div_fn_t      divreq_fn,
  input  div_operand_t divreq_a,
  input  div_operand_t divreq_b,
  output div_operand_t mag_a,
  output div_operand_t mag_b,
  input  div_operand_t quot_mag,
  input  div_operand_t rem_mag,
  output div_result_t  divresp_result
);

  // two's complement when neg is set, pass through otherwise
  function automatic div_operand_t negate_if(input logic neg, input div_operand_t val);
    negate_if = neg ? (~val + 1'b1) : val;
  endfunction

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic quot_neg;
  logic rem_neg;

  // ------------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------------

  assign is_signed = (divreq_fn == DIV_FN_SIGNED);

  // sign bits only count for signed requests
  assign a_neg = is_signed & divreq_a[31];
  assign b_neg = is_signed & divreq_b[31];

  assign mag_a = negate_if(a_neg, divreq_a);
  assign mag_b = negate_if(b_neg, divreq_b);

  // ------------------------------------------------------------------------
  // result sign flags
  // ------------------------------------------------------------------------

  // captured on the request transfer, held until the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (sign_en) begin
      // quotient negative when exactly one operand is negative
      quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
    end
  end

  // remainder in the upper half, quotient in the lower half
  assign divresp_result = {negate_if(rem_neg, rem_mag), negate_if(quot_neg, quot_mag)};

endmodule

`default_nettype wire

//--- rtl/int_div_dpath.sv
/*
  divider datapath
  restoring shift-subtract accumulator, divisor register and step counter
*/

`timescale 1ns/10ps
`default_nettype none

module int_div_dpath
  import div_msg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         a_en,
  input  logic         b_en,
  input  div_a_sel_e   a_sel,
  input  div_operand_t mag_a,
  input  div_operand_t mag_b,
  output logic         counter_done,
  output div_operand_t quot_mag,
  output div_operand_t rem_mag
);

  div_acc_t   acc;
  div_acc_t   div_reg;
  div_acc_t   acc_init;
  div_acc_t   acc_shift;
  div_acc_t   acc_diff;
  div_acc_t   acc_step;
  div_acc_t   acc_next;
  div_count_t count;
  logic       load;
  logic       step;

  assign load = a_en & (a_sel == A_SEL_LOAD);
  assign step = a_en & (a_sel == A_SEL_STEP);

  // ------------------------------------------------------------------------
  // shift-subtract step
  // ------------------------------------------------------------------------

  // dividend magnitude in the low half, remainder part starts at zero
  assign acc_init = {33'b0, mag_a};

  assign acc_shift = acc << 1;

  // divisor sits over the remainder part, so the low half only shifts
  assign acc_diff = acc_shift - div_reg;

  // no borrow means the divisor fit, keep the difference with a 1 bit
  // a borrow restores the shifted value with a 0 bit
  always_comb begin
    if (acc_diff[64]) begin
      acc_step = {acc_shift[64:1], 1'b0};
    end else begin
      acc_step = {acc_diff[64:1], 1'b1};
    end
  end

  assign acc_next = (a_sel == A_SEL_LOAD) ? acc_init : acc_step;

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      acc <= acc_next;
    end
  end

  // divisor aligned to the remainder half of the accumulator
  always_ff @(posedge clk) begin
    if (b_en) begin
      div_reg <= {1'b0, mag_b, 32'b0};
    end
  end

  // step counter
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  // high during the last of the DIV_STEPS steps
  assign counter_done = (count == div_count_t'(DIV_STEPS - 1));

  assign quot_mag = acc[31:0];
  assign rem_mag  = acc[63:32];

endmodule

`default_nettype wire

//--- rtl/int_div_ctrl.sv
/*
  divider control unit
  idle/calc/done FSM for the val/rdy handshake and the datapath enables
*/

`timescale 1ns/10ps
`default_nettype none

module int_div_ctrl
  import div_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       divreq_val,
  input  logic       divresp_rdy,
  output logic       divreq_rdy,
  output logic       divresp_val,
  input  logic       counter_done,
  output logic       a_en,
  output logic       b_en,
  output logic       sign_en,
  output div_a_sel_e a_sel
);

  div_state_e state;
  div_state_e state_next;
  logic       req_go;
  logic       resp_go;

  // transfers on both sides of the unit
  assign req_go  = divreq_val & divreq_rdy;
  assign resp_go = divresp_val & divresp_rdy;

  // ------------------------------------------------------------------------
  // state register and next state
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (req_go) state_next = ST_CALC;
      // last step is taken on the same edge that leaves calc
      ST_CALC: if (counter_done) state_next = ST_DONE;
      ST_DONE: if (resp_go) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------

  always_comb begin
    divreq_rdy  = 1'b0;
    divresp_val = 1'b0;
    a_en        = 1'b0;
    b_en        = 1'b0;
    sign_en     = 1'b0;
    a_sel       = A_SEL_LOAD;
    case (state)
      ST_IDLE: begin
        // ready does not look at val
        divreq_rdy = 1'b1;
        // load operands and capture signs on the transfer edge
        a_en    = divreq_val;
        b_en    = divreq_val;
        sign_en = divreq_val;
      end
      ST_CALC: begin
        // one quotient bit every cycle
        a_en  = 1'b1;
        a_sel = A_SEL_STEP;
      end
      ST_DONE: begin
        // accumulator and sign flags hold while waiting for rdy
        divresp_val = 1'b1;
      end
      default: begin
        divreq_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/int_div_iterative.sv
/*
  iterative 32-bit integer divider, signed and unsigned, one bit per cycle
*/

`timescale 1ns/10ps
`default_nettype none

module int_div_iterative
  import div_msg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  div_fn_t      divreq_fn,
  input  div_operand_t divreq_a,
  input  div_operand_t divreq_b,
  input  logic         divreq_val,
  output logic         divreq_rdy,
  output div_result_t  divresp_result,
  output logic         divresp_val,
  input  logic         divresp_rdy
);

  // control to datapath and sign unit
  logic         a_en;
  logic         b_en;
  logic         sign_en;
  div_a_sel_e   a_sel;
  logic         counter_done;

  // magnitudes in and out of the datapath
  div_operand_t mag_a;
  div_operand_t mag_b;
  div_operand_t quot_mag;
  div_operand_t rem_mag;

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  int_div_ctrl u_int_div_ctrl (
    .clk          (clk),
    .reset        (reset),
    .divreq_val   (divreq_val),
    .divresp_rdy  (divresp_rdy),
    .divreq_rdy   (divreq_rdy),
    .divresp_val  (divresp_val),
    .counter_done (counter_done),
    .a_en         (a_en),
    .b_en         (b_en),
    .sign_en      (sign_en),
    .a_sel        (a_sel)
  );

  // ------------------------------------------------------------------------
  // datapath and sign handling
  // ------------------------------------------------------------------------

  int_div_dpath u_int_div_dpath (
    .clk          (clk),
    .reset        (reset),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_sel        (a_sel),
    .mag_a        (mag_a),
    .mag_b        (mag_b),
    .counter_done (counter_done),
    .quot_mag     (quot_mag),
    .rem_mag      (rem_mag)
  );

  // magnitudes go straight from the request into the datapath on load
  int_div_sign u_int_div_sign (
    .clk            (clk),
    .reset          (reset),
    .sign_en        (sign_en),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .mag_a          (mag_a),
    .mag_b          (mag_b),
    .quot_mag       (quot_mag),
    .rem_mag        (rem_mag),
    .divresp_result (divresp_result)
  );

endmodule

`default_nettype wire

//--- tb/div_ref_model.svh
/*
  reference division for the divider testbench
  expected quotient and remainder, division by zero included
*/

`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// unsigned division, remainder in the upper half
// divide by zero gives an all ones quotient and the dividend as remainder
function automatic div_result_t ref_unsigned(input div_operand_t a, input div_operand_t b);
  div_operand_t quot;
  div_operand_t rem;
  if (b == '0) begin
    quot = '1;
    rem  = a;
  end else begin
    quot = a / b;
    rem  = a % b;
  end
  return {rem, quot};
endfunction

// signed division on magnitudes, then the sign rules
function automatic div_result_t ref_signed(input div_operand_t a, input div_operand_t b);
  logic         a_neg;
  logic         b_neg;
  div_operand_t quot;
  div_operand_t rem;
  div_result_t  mag;
  a_neg = a[31];
  b_neg = b[31];
  mag   = ref_unsigned(a_neg ? -a : a, b_neg ? -b : b);
  // quotient negative for differing signs, remainder follows the dividend
  quot  = (a_neg ^ b_neg) ? -mag[31:0] : mag[31:0];
  rem   = a_neg ? -mag[63:32] : mag[63:32];
  return {rem, quot};
endfunction

`endif

//--- tb/tb_int_div.sv
/*
  testbench for the iterative integer divider
  directed and random requests, latency and response back-pressure checks
*/

`timescale 1ns/10ps
`default_nettype none

module tb_int_div
  import div_msg_pkg::*;
;

  `include "div_ref_model.svh"

  localparam int unsigned SEED = 32'h1ec75d88;
  localparam int LATENCY    = 32;
  localparam int NUM_RANDOM = 16;
  localparam int NUM_BP     = 4;
  // fixed unsigned, fixed signed and divide by zero requests
  localparam int NUM_FIXED  = 17;
  localparam int NUM_REQS   = 2 * NUM_RANDOM + NUM_FIXED + NUM_BP;
  // each request about 40 cycles, plus the back-pressure holds and reset
  localparam int CYCLE_LIMIT = NUM_REQS * 40 + NUM_BP * 16 + 100;

  logic         clk;
  logic         reset;
  div_fn_t      divreq_fn;
  div_operand_t divreq_a;
  div_operand_t divreq_b;
  logic         divreq_val;
  logic         divreq_rdy;
  div_result_t  divresp_result;
  logic         divresp_val;
  logic         divresp_rdy;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  int_div_iterative u_int_div_iterative (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, run still busy after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // random divisor, shifted down so small divisors show up too
  function automatic div_operand_t random_divisor();
    div_operand_t val;
    val = $urandom();
    return val >> ($urandom() % 32);
  endfunction

  // one request, called on a falling edge
  // hold is the number of cycles divresp_rdy stays low once the response is up
  task automatic run_division(input div_fn_t fn, input div_operand_t a,
                              input div_operand_t b, input int hold);
    div_result_t expected;
    int          lat;
    expected   = (fn == DIV_FN_SIGNED) ? ref_signed(a, b) : ref_unsigned(a, b);
    divreq_fn  = fn;
    divreq_a   = a;
    divreq_b   = b;
    divreq_val = 1'b1;
    while (!divreq_rdy) @(negedge clk);
    // transfer happens on the next rising edge
    @(negedge clk);
    divreq_val = 1'b0;
    // operands must already be captured
    divreq_a   = $urandom();
    divreq_b   = $urandom();
    // rising edges seen since the transfer edge
    lat = 0;
    while (!divresp_val && lat <= LATENCY + 8) begin
      // one request in flight at a time
      check_equal("divreq_rdy", divreq_rdy, 1'b0);
      @(negedge clk);
      lat++;
    end
    check_equal("latency", lat, LATENCY);
    check_equal("divresp_result", divresp_result, expected);
    // offer another request while the response is stalled
    if (hold > 0) begin
      divreq_val = 1'b1;
      divreq_fn  = ~fn;
    end
    repeat (hold) begin
      @(negedge clk);
      check_equal("divresp_val", divresp_val, 1'b1);
      check_equal("divresp_result", divresp_result, expected);
      check_equal("divreq_rdy", divreq_rdy, 1'b0);
    end
    divreq_val  = 1'b0;
    divresp_rdy = 1'b1;
    @(negedge clk);
    divresp_rdy = 1'b0;
    // back in idle right after the response transfer
    check_equal("divresp_val", divresp_val, 1'b0);
    check_equal("divreq_rdy", divreq_rdy, 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    check_equal("divreq_rdy", divreq_rdy, 1'b1);
    check_equal("divresp_val", divresp_val, 1'b0);
  endtask

  task automatic test_unsigned();
    div_operand_t a;
    div_operand_t b;
    run_division(1'b0, 100, 7, 0);
    run_division(1'b0, 32'hffff_ffff, 1, 0);
    run_division(1'b0, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_division(1'b0, 5, 10, 0);
    run_division(1'b0, 32'h8000_0000, 3, 0);
    run_division(1'b0, 0, 5, 0);
    run_division(1'b0, 12345678, 32'h0001_0000, 0);
    repeat (NUM_RANDOM) begin
      a = $urandom();
      b = random_divisor();
      run_division(1'b0, a, b, 0);
    end
  endtask

  task automatic test_signed();
    div_operand_t a;
    div_operand_t b;
    // all four sign combinations
    run_division(1'b1, 100, 7, 0);
    run_division(1'b1, -100, 7, 0);
    run_division(1'b1, 100, -7, 0);
    run_division(1'b1, -100, -7, 0);
    run_division(1'b1, -7, 100, 0);
    // most negative dividend over minus one wraps back to itself
    run_division(1'b1, 32'h8000_0000, 32'hffff_ffff, 0);
    repeat (NUM_RANDOM) begin
      a = $urandom();
      b = random_divisor();
      if ($urandom() % 2) begin
        b = -b;
      end
      run_division(1'b1, a, b, 0);
    end
  endtask

  task automatic test_divide_by_zero();
    run_division(1'b0, 1234, 0, 0);
    run_division(1'b0, 0, 0, 0);
    run_division(1'b1, -1234, 0, 0);
    run_division(1'b1, 1234, 0, 0);
  endtask

  task automatic test_back_pressure();
    div_operand_t a;
    div_operand_t b;
    int           hold;
    repeat (NUM_BP) begin
      a    = $urandom();
      b    = random_divisor();
      hold = 1 + ($urandom() % 15);
      run_division(div_fn_t'($urandom() % 2), a, b, hold);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    reset       = 1'b1;
    divreq_fn   = 1'b0;
    divreq_a    = '0;
    divreq_b    = '0;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_unsigned();
    test_signed();
    test_divide_by_zero();
    test_back_pressure();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
rtl/div_msg_pkg.sv
rtl/div_ctrl_pkg.sv
rtl/int_div_sign.sv
rtl/int_div_dpath.sv
rtl/int_div_ctrl.sv
rtl/int_div_iterative.sv
tb/tb_int_div.sv
